/* cpu_isa_pkg.sv */
// instruction set encodings for the 16-bit core, imported by the fetch and decode blocks
package cpu_isa_pkg;

	localparam int WORD_W = 16;			// instruction and data word

	typedef logic [WORD_W-1:0] word_t;

	localparam word_t NOP_WORD = '0;		// all-zero word decodes to nothing

	// class select lives in the top nibble
	localparam int F_CLS_HI  = 15;
	localparam int F_CLS_LO  = 12;
	localparam int F_CLS3_LO = 13;			// three-bit code for classes 8 and 9

	localparam logic [3:0] CLS_MISC   = 4'h0;	// nop, inc/dec multiple
	localparam logic [3:0] CLS_IMM    = 4'h1;	// 12-bit immediate prefix
	localparam logic [3:0] CLS_ALU_RR = 4'h2;	// alu reg, reg
	localparam logic [3:0] CLS_ALU_RI = 4'h3;	// alu reg, imm4
	localparam logic [3:0] CLS_BRANCH = 4'h4;	// absolute branch
	localparam logic [3:0] CLS_MEM_RR = 4'h5;	// load/store, reg index

	localparam logic [2:0] CLS3_ALU_RRR = 3'b100;	// alu reg, reg, reg

	// class 0 sub-ops
	localparam int F_SUBOP_HI = 11;
	localparam int F_SUBOP_LO = 8;
	localparam logic [3:0] MISC_INC_MULTI = 4'h2;
	localparam logic [3:0] MISC_DEC_MULTI = 4'h3;

	// alu fields, classes 2 and 3
	localparam int F_ALU_OP_HI = 11;
	localparam int F_ALU_OP_LO = 8;
	localparam int F_ALU_HB    = 3;			// op bit 4, class 2 only
	localparam int F_DEST_HI   = 6;
	localparam int F_DEST_LO   = 4;
	localparam int F_SRC_HI    = 2;
	localparam int F_SRC_LO    = 0;
	localparam int F_NO_STORE  = 7;			// set for cmp / test style ops

	// immediates
	localparam int F_IMM4_HI  = 3;
	localparam int F_IMM4_LO  = 0;
	localparam int F_IMM12_HI = 11;
	localparam int F_IMM12_LO = 0;

	// branch fields
	localparam int F_COND_HI   = 10;
	localparam int F_COND_LO   = 8;
	localparam int F_BR_INDIR  = 11;		// target from register + imm

	// memory fields, index in src slot, data reg in dest slot
	localparam int F_MEM_STORE   = 8;		// 0 load, 1 store
	localparam int F_MEM_NO_PINC = 9;		// active low post-increment
	localparam int F_MEM_NO_PDEC = 10;		// active low post-decrement

	// three-register alu fields
	localparam int F_RRR_OP_HI   = 12;
	localparam int F_RRR_OP_LO   = 9;
	localparam int F_RRR_DEST_HI = 8;
	localparam int F_RRR_DEST_LO = 6;
	localparam int F_RRR_SRC2_HI = 5;
	localparam int F_RRR_SRC2_LO = 3;

	typedef enum logic [2:0] {
		BZ  = 3'd0,				// zero
		BNZ = 3'd1,				// not zero
		BS  = 3'd2,				// sign
		BNS = 3'd3,				// not sign
		BC  = 3'd4,				// carry
		BNC = 3'd5,				// no carry
		BA  = 3'd6,				// always
		BL  = 3'd7				// link form, never taken here
	} cond_t;

endpackage

/* cpu_ctrl_pkg.sv */
// register file and alu control constants shared by the decode stages and the top level
package cpu_ctrl_pkg;

	localparam int NUM_REGS  = 8;
	localparam int REG_IDX_W = $clog2(NUM_REGS);
	localparam int ALU_OP_W  = 5;			// op nibble plus high bit
	localparam int IMM_W     = 12;			// prefix width

	typedef logic [REG_IDX_W-1:0] reg_idx_t;
	typedef logic [NUM_REGS-1:0]  reg_mask_t;	// active low, one bit per reg
	typedef logic [ALU_OP_W-1:0]  alu_op_t;

	localparam reg_idx_t PC_IDX = 3'd7;		// r7 is the program counter

	localparam alu_op_t ALU_MOVE = 5'd0;
	localparam alu_op_t ALU_ADD  = 5'd1;

	localparam reg_mask_t MASK_NONE = '1;		// nothing selected

	// mask with just one register pulled low
	function automatic reg_mask_t reg_sel_low(input reg_idx_t idx);
		reg_mask_t m;
		m = MASK_NONE;
		m[idx] = 1'b0;
		return m;
	endfunction

endpackage

/* fetch_sequencer.sv */
// pipeline stage registers plus the stall and delay-slot state that steer instruction fetch
`timescale 1ns/1ps

module fetch_sequencer import cpu_isa_pkg::*; (
	input  logic  CLK,
	input  logic  RSTb,
	input  word_t memoryIn,
	input  logic  feed_nop,		// stage 0 decode squashes the incoming word
	input  logic  stall_req,	// load in stage 0
	input  logic  delay_req,	// taken branch in stage 0
	output word_t stage0,
	output word_t stage1,
	output logic  fetching,		// memoryIn goes into stage 0 this edge
	output logic  fetch_slot	// PC drives the address bus this cycle
);

	word_t stage0_q;
	word_t stage1_q;
	word_t stage0_d;
	logic  stall_q;			// load finishing in stage 1
	logic  delay_q;			// branch delay slot

	// stall cycle owns the memory bus for the load
	// delay slot still fetches but the word is thrown away
	assign fetch_slot = ~stall_q;
	assign fetching   = ~(stall_q | delay_q | feed_nop);

	always_comb begin
		if (fetching) begin
			stage0_d = memoryIn;	// normal fetch
		end else begin
			stage0_d = NOP_WORD;	// bubble
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			stage0_q <= NOP_WORD;
			stage1_q <= NOP_WORD;
			stall_q  <= 1'b0;
			delay_q  <= 1'b0;
		end else begin
			stage0_q <= stage0_d;
			stage1_q <= stage0_q;	// stage 1 always follows
			stall_q  <= stall_req;	// one cycle only
			delay_q  <= delay_req;
		end
	end

	assign stage0 = stage0_q;
	assign stage1 = stage1_q;

endmodule

/* stage0_decode.sv */
// decodes the stage-0 word into register file, alu and memory strobes and holds the imm prefix
`timescale 1ns/1ps

module stage0_decode import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
	input  logic      CLK,
	input  logic      RSTb,
	input  word_t     stage0,
	input  logic      C,
	input  logic      Z,
	input  logic      S,
	input  logic      fetch_slot,	// PC fetch runs this cycle
	output logic      feed_nop,
	output logic      stall_req,
	output logic      delay_req,
	output alu_op_t   alu_op,
	output word_t     pout,
	output reg_mask_t ld_alu,	// all masks active low
	output reg_mask_t ld_mem,
	output reg_mask_t ld_pout,
	output reg_mask_t inc,
	output reg_mask_t dec,
	output reg_idx_t  alu_a_sel,
	output reg_idx_t  alu_b_sel,
	output reg_idx_t  m_sel,
	output reg_idx_t  maddr_sel,
	output logic      m_en,		// active low
	output logic      b_from_imm,	// active low, alu B from pout
	output logic      mem_oe,	// active low
	output logic      mem_wr	// active low
);

	logic [IMM_W-1:0]             imm_q;	// prefix from a class 1 word
	logic [IMM_W-1:0]             imm_d;
	logic [F_IMM4_HI:F_IMM4_LO]   pout_lo;
	logic [F_CLS_HI-F_CLS_LO:0]   cls;
	reg_idx_t                     dest;
	reg_idx_t                     src;	// also the memory index
	reg_idx_t                     rrr_dest;
	reg_idx_t                     rrr_src2;
	logic                         taken;

	function automatic logic cond_met(input cond_t cond, input logic c, input logic z,
		input logic s);
		case (cond)
			BZ:      return z;
			BNZ:     return ~z;
			BS:      return s;
			BNS:     return ~s;
			BC:      return c;
			BNC:     return ~c;
			BA:      return 1'b1;
			default: return 1'b0;	// BL not supported
		endcase
	endfunction

	assign cls      = stage0[F_CLS_HI:F_CLS_LO];
	assign dest     = stage0[F_DEST_HI:F_DEST_LO];
	assign src      = stage0[F_SRC_HI:F_SRC_LO];
	assign rrr_dest = stage0[F_RRR_DEST_HI:F_RRR_DEST_LO];
	assign rrr_src2 = stage0[F_RRR_SRC2_HI:F_RRR_SRC2_LO];
	assign taken    = cond_met(cond_t'(stage0[F_COND_HI:F_COND_LO]), C, Z, S);

	always_comb begin
		alu_op     = ALU_MOVE;
		pout_lo    = '0;
		ld_alu     = MASK_NONE;
		ld_mem     = MASK_NONE;
		ld_pout    = MASK_NONE;
		inc        = MASK_NONE;
		dec        = MASK_NONE;
		alu_a_sel  = '0;
		alu_b_sel  = '0;
		m_sel      = '0;
		maddr_sel  = '0;
		m_en       = 1'b1;
		b_from_imm = 1'b1;
		mem_oe     = 1'b1;
		mem_wr     = 1'b1;
		feed_nop   = 1'b0;
		stall_req  = 1'b0;
		delay_req  = 1'b0;
		imm_d      = '0;		// prefix lasts one word only

		// fetch defaults, overridden by the class below
		if (fetch_slot) begin
			maddr_sel   = PC_IDX;
			inc[PC_IDX] = 1'b0;	// post-increment PC
			mem_oe      = 1'b0;
		end

		if (stage0[F_CLS_HI:F_CLS3_LO] == CLS3_ALU_RRR) begin
			alu_op    = {1'b0, stage0[F_RRR_OP_HI:F_RRR_OP_LO]};
			alu_a_sel = rrr_src2;
			alu_b_sel = src;
			ld_alu    = reg_sel_low(rrr_dest);	// always stored
		end else begin
			case (cls)
				CLS_MISC: begin
					if (stage0[F_SUBOP_HI:F_SUBOP_LO] == MISC_INC_MULTI)
						inc[PC_IDX-1:0] = stage0[PC_IDX-1:0];	// low bits are the mask
					else if (stage0[F_SUBOP_HI:F_SUBOP_LO] == MISC_DEC_MULTI)
						dec[PC_IDX-1:0] = stage0[PC_IDX-1:0];
				end
				CLS_IMM: begin
					imm_d = stage0[F_IMM12_HI:F_IMM12_LO];
				end
				CLS_ALU_RR: begin
					alu_op    = {stage0[F_ALU_HB], stage0[F_ALU_OP_HI:F_ALU_OP_LO]};
					alu_a_sel = dest;
					alu_b_sel = src;
					if (!stage0[F_NO_STORE])
						ld_alu = reg_sel_low(dest);
				end
				CLS_ALU_RI: begin
					alu_op     = {1'b0, stage0[F_ALU_OP_HI:F_ALU_OP_LO]};
					pout_lo    = stage0[F_IMM4_HI:F_IMM4_LO];
					alu_a_sel  = dest;
					b_from_imm = 1'b0;	// B from {imm, imm4}
					if (!stage0[F_NO_STORE])
						ld_alu = reg_sel_low(dest);
				end
				CLS_BRANCH: begin
					if (taken) begin
						feed_nop    = 1'b1;
						inc[PC_IDX] = 1'b1;	// hold PC
						delay_req   = 1'b1;
						if (stage0[F_BR_INDIR]) begin
							ld_alu     = reg_sel_low(PC_IDX);	// PC = reg + pout
							b_from_imm = 1'b0;
							alu_op     = ALU_ADD;
							alu_a_sel  = dest;
						end else begin
							ld_pout = reg_sel_low(PC_IDX);	// PC = pout
							pout_lo = stage0[F_IMM4_HI:F_IMM4_LO];
						end
					end
				end
				CLS_MEM_RR: begin
					maddr_sel   = src;		// index reg
					feed_nop    = 1'b1;		// fetched word is lost
					dec[PC_IDX] = 1'b0;	// step PC back to refetch
					if (!stage0[F_MEM_STORE]) begin
						stall_req = 1'b1;	// data arrives next cycle
					end else begin
						m_en     = 1'b0;
						m_sel    = dest;	// data reg
						mem_oe   = 1'b1;
						mem_wr   = 1'b0;
						inc[src] = stage0[F_MEM_NO_PINC];
						dec[src] = stage0[F_MEM_NO_PDEC];
					end
					inc[PC_IDX] = 1'b1;	// wins over index r7
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb)
			imm_q <= '0;
		else
			imm_q <= imm_d;
	end

	assign pout = {imm_q, pout_lo};		// prefix sits above imm4

endmodule

/* stage1_decode.sv */
// finishes a load held in stage 1 by overriding the stage-0 strobes, otherwise passes them on
`timescale 1ns/1ps

module stage1_decode import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
	input  word_t     stage1,
	input  alu_op_t   s0_alu_op,
	input  word_t     s0_pout,
	input  reg_mask_t s0_ld_alu,
	input  reg_mask_t s0_ld_mem,
	input  reg_mask_t s0_ld_pout,
	input  reg_mask_t s0_inc,
	input  reg_mask_t s0_dec,
	input  reg_idx_t  s0_alu_a_sel,
	input  reg_idx_t  s0_alu_b_sel,
	input  reg_idx_t  s0_m_sel,
	input  reg_idx_t  s0_maddr_sel,
	input  logic      s0_m_en,
	input  logic      s0_b_from_imm,
	input  logic      s0_mem_oe,
	input  logic      s0_mem_wr,
	output alu_op_t   aluOp,
	output word_t     pout,
	output reg_mask_t LD_reg_ALUb,
	output reg_mask_t LD_reg_Mb,
	output reg_mask_t LD_reg_Pb,
	output reg_idx_t  ALU_A_SEL,
	output reg_idx_t  ALU_B_SEL,
	output logic      M_ENb,
	output reg_idx_t  M_SEL,
	output reg_idx_t  MADDR_SEL,
	output reg_mask_t INCb,
	output reg_mask_t DECb,
	output logic      ALU_B_from_inP_b,
	output logic      mem_OEb,
	output logic      mem_WRb
);

	logic     load1;		// class 5 load in stage 1
	reg_idx_t idx;
	reg_idx_t dest;

	assign load1 = (stage1[F_CLS_HI:F_CLS_LO] == CLS_MEM_RR) && !stage1[F_MEM_STORE];
	assign idx   = stage1[F_SRC_HI:F_SRC_LO];
	assign dest  = stage1[F_DEST_HI:F_DEST_LO];

	// untouched by a load
	assign aluOp            = s0_alu_op;
	assign pout             = s0_pout;
	assign LD_reg_ALUb      = s0_ld_alu;
	assign LD_reg_Pb        = s0_ld_pout;
	assign ALU_A_SEL        = s0_alu_a_sel;
	assign ALU_B_SEL        = s0_alu_b_sel;
	assign M_ENb            = s0_m_en;
	assign M_SEL            = s0_m_sel;
	assign ALU_B_from_inP_b = s0_b_from_imm;

	always_comb begin
		MADDR_SEL = s0_maddr_sel;
		mem_OEb   = s0_mem_oe;
		mem_WRb   = s0_mem_wr;
		LD_reg_Mb = s0_ld_mem;
		INCb      = s0_inc;
		DECb      = s0_dec;
		if (load1) begin
			MADDR_SEL = idx;		// address from index reg
			mem_OEb   = 1'b0;
			mem_WRb   = 1'b1;
			LD_reg_Mb = reg_sel_low(dest);	// capture memory data
			INCb[idx] = stage1[F_MEM_NO_PINC];
			DECb[idx] = stage1[F_MEM_NO_PDEC];
		end
	end

endmodule

/* pipeline_ctrl.sv */
// top level of the two-stage control unit, wires fetch, stage-0 and stage-1 decode together
`timescale 1ns/1ps

module pipeline_ctrl import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
	input  logic      CLK,
	input  logic      RSTb,
	input  word_t     memoryIn,
	input  logic      C,		// alu flags
	input  logic      Z,
	input  logic      S,
	output alu_op_t   aluOp,
	output word_t     pout,
	output reg_mask_t LD_reg_ALUb,
	output reg_mask_t LD_reg_Mb,
	output reg_mask_t LD_reg_Pb,
	output reg_idx_t  ALU_A_SEL,
	output reg_idx_t  ALU_B_SEL,
	output logic      M_ENb,
	output reg_idx_t  M_SEL,
	output reg_idx_t  MADDR_SEL,
	output reg_mask_t INCb,
	output reg_mask_t DECb,
	output logic      ALU_B_from_inP_b,
	output logic      mem_OEb,
	output logic      mem_WRb
);

	word_t     stage0;
	word_t     stage1;
	logic      fetch_slot;
	logic      feed_nop;
	logic      stall_req;
	logic      delay_req;
	alu_op_t   s0_alu_op;
	word_t     s0_pout;
	reg_mask_t s0_ld_alu;
	reg_mask_t s0_ld_mem;
	reg_mask_t s0_ld_pout;
	reg_mask_t s0_inc;
	reg_mask_t s0_dec;
	reg_idx_t  s0_alu_a_sel;
	reg_idx_t  s0_alu_b_sel;
	reg_idx_t  s0_m_sel;
	reg_idx_t  s0_maddr_sel;
	logic      s0_m_en;
	logic      s0_b_from_imm;
	logic      s0_mem_oe;
	logic      s0_mem_wr;

	fetch_sequencer u_fetch (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.memoryIn   (memoryIn),
		.feed_nop   (feed_nop),
		.stall_req  (stall_req),
		.delay_req  (delay_req),
		.stage0     (stage0),
		.stage1     (stage1),
		.fetching   (),		// status only, probed from the testbench
		.fetch_slot (fetch_slot)
	);

	stage0_decode u_dec0 (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.stage0     (stage0),
		.C          (C),
		.Z          (Z),
		.S          (S),
		.fetch_slot (fetch_slot),
		.feed_nop   (feed_nop),
		.stall_req  (stall_req),
		.delay_req  (delay_req),
		.alu_op     (s0_alu_op),
		.pout       (s0_pout),
		.ld_alu     (s0_ld_alu),
		.ld_mem     (s0_ld_mem),
		.ld_pout    (s0_ld_pout),
		.inc        (s0_inc),
		.dec        (s0_dec),
		.alu_a_sel  (s0_alu_a_sel),
		.alu_b_sel  (s0_alu_b_sel),
		.m_sel      (s0_m_sel),
		.maddr_sel  (s0_maddr_sel),
		.m_en       (s0_m_en),
		.b_from_imm (s0_b_from_imm),
		.mem_oe     (s0_mem_oe),
		.mem_wr     (s0_mem_wr)
	);

	stage1_decode u_dec1 (
		.stage1           (stage1),
		.s0_alu_op        (s0_alu_op),
		.s0_pout          (s0_pout),
		.s0_ld_alu        (s0_ld_alu),
		.s0_ld_mem        (s0_ld_mem),
		.s0_ld_pout       (s0_ld_pout),
		.s0_inc           (s0_inc),
		.s0_dec           (s0_dec),
		.s0_alu_a_sel     (s0_alu_a_sel),
		.s0_alu_b_sel     (s0_alu_b_sel),
		.s0_m_sel         (s0_m_sel),
		.s0_maddr_sel     (s0_maddr_sel),
		.s0_m_en          (s0_m_en),
		.s0_b_from_imm    (s0_b_from_imm),
		.s0_mem_oe        (s0_mem_oe),
		.s0_mem_wr        (s0_mem_wr),
		.aluOp            (aluOp),
		.pout             (pout),
		.LD_reg_ALUb      (LD_reg_ALUb),
		.LD_reg_Mb        (LD_reg_Mb),
		.LD_reg_Pb        (LD_reg_Pb),
		.ALU_A_SEL        (ALU_A_SEL),
		.ALU_B_SEL        (ALU_B_SEL),
		.M_ENb            (M_ENb),
		.M_SEL            (M_SEL),
		.MADDR_SEL        (MADDR_SEL),
		.INCb             (INCb),
		.DECb             (DECb),
		.ALU_B_from_inP_b (ALU_B_from_inP_b),
		.mem_OEb          (mem_OEb),
		.mem_WRb          (mem_WRb)
	);

endmodule

/* tb_clock.sv */
// testbench clock and reset source for the control unit, 100 ns period, reset low for four edges
`timescale 1ns/1ps

module tb_clock (
	output logic CLK,
	output logic RSTb
);

	localparam int HALF_PERIOD  = 50;	// ns
	localparam int RESET_CYCLES = 4;

	initial begin
		CLK = 1'b0;
		forever #HALF_PERIOD CLK = ~CLK;
	end

	initial begin
		RSTb = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		#5 RSTb = 1'b1;			// off the edge, same as other stimulus
	end

endmodule

/* tb_tests.svh */
// directed test tasks for the control unit testbench, included inside the testbench top module

	function automatic logic branch_taken(input cond_t cond, input logic c, input logic z,
		input logic s);
		logic [7:0] row;
		row = {1'b0, 1'b1, ~c, c, ~s, s, ~z, z};	// BL down to BZ
		return row[cond];
	endfunction

	task automatic test_reset_idle();
		wait_reset_release();
		repeat (4) begin
			drive_word(NOP_WORD);
			check_idx("MADDR_SEL", MADDR_SEL, PC_IDX);
			check_mask("INCb", INCb, 8'h7f);		// PC post-increment
			check_bit("mem_OEb", mem_OEb, 1'b0);
			check_mask("LD_reg_ALUb", LD_reg_ALUb, MASK_NONE);
			check_mask("LD_reg_Mb", LD_reg_Mb, MASK_NONE);
			check_mask("LD_reg_Pb", LD_reg_Pb, MASK_NONE);
			check_mask("DECb", DECb, MASK_NONE);
			check_bit("mem_WRb", mem_WRb, 1'b1);
			check_bit("M_ENb", M_ENb, 1'b1);
			check_bit("ALU_B_from_inP_b", ALU_B_from_inP_b, 1'b1);
			advance();
		end
	endtask

	task automatic test_alu_classes();
		logic [31:0] r;
		logic [3:0]  op;
		logic [3:0]  rop;
		logic        hb;
		reg_idx_t    d;
		reg_idx_t    s;
		reg_idx_t    s2;
		int          i;
		for (i = 0; i < 4; i++) begin
			r   = next_random();
			op  = r[3:0];
			d   = r[6:4];
			s   = r[10:8];
			s2  = r[14:12];
			hb  = r[16];
			rop = {i[0], op[2:0]};			// class 8 and 9 in turn
			present_word({CLS_ALU_RR, op, 1'b0, d, hb, s});
			drive_word(NOP_WORD);
			check_op("aluOp rr", aluOp, {hb, op});
			check_idx("ALU_A_SEL rr", ALU_A_SEL, d);
			check_idx("ALU_B_SEL rr", ALU_B_SEL, s);
			check_mask("LD_reg_ALUb rr", LD_reg_ALUb, mask_bit(MASK_NONE, d, 1'b0));
			advance();
			present_word({CLS_ALU_RR, op, 1'b1, d, hb, s});	// no-store form
			drive_word(NOP_WORD);
			check_mask("LD_reg_ALUb no-store", LD_reg_ALUb, MASK_NONE);
			advance();
			present_word({CLS3_ALU_RRR, rop, d, s2, s});
			drive_word(NOP_WORD);
			check_op("aluOp rrr", aluOp, {1'b0, rop});
			check_idx("ALU_A_SEL rrr", ALU_A_SEL, s2);
			check_idx("ALU_B_SEL rrr", ALU_B_SEL, s);
			check_mask("LD_reg_ALUb rrr", LD_reg_ALUb, mask_bit(MASK_NONE, d, 1'b0));
			advance();
		end
	endtask

	task automatic test_imm_prefix();
		logic [31:0] r;
		logic [11:0] imm12;
		logic [3:0]  imm4;
		logic [3:0]  op;
		reg_idx_t    d;
		r     = next_random();
		imm12 = r[11:0];
		imm4  = r[15:12];
		op    = r[19:16];
		d     = r[22:20];
		present_word({CLS_IMM, imm12});
		present_word({CLS_ALU_RI, op, 1'b0, d, imm4});	// right behind the prefix
		drive_word(NOP_WORD);
		check_word("pout with prefix", pout, {imm12, imm4});
		check_bit("ALU_B_from_inP_b", ALU_B_from_inP_b, 1'b0);
		check_op("aluOp ri", aluOp, {1'b0, op});
		check_mask("LD_reg_ALUb ri", LD_reg_ALUb, mask_bit(MASK_NONE, d, 1'b0));
		advance();
		present_word({CLS_ALU_RI, op, 1'b0, d, imm4});	// prefix has expired
		drive_word(NOP_WORD);
		check_word("pout bare", pout, {12'h000, imm4});
		advance();
	endtask

	task automatic test_branches();
		logic [31:0] r;
		logic [3:0]  imm4;
		logic [3:0]  op;
		reg_idx_t    d;
		reg_idx_t    s;
		word_t       wa;
		logic        taken;
		int          c;
		int          k;
		for (c = 0; c < 16; c++) begin
			r    = next_random();
			C    = r[0];
			Z    = r[1];
			S    = r[2];
			imm4 = r[7:4];
			d    = r[10:8];
			s    = r[13:11];
			op   = r[19:16];
			wa   = {CLS_ALU_RR, op, 1'b0, d, 1'b0, s};	// word behind the branch
			taken = branch_taken(cond_t'(c[2:0]), r[0], r[1], r[2]);
			present_word({CLS_BRANCH, 1'b0, c[2:0], 4'h0, imm4});
			drive_word(wa);
			check_mask("LD_reg_Pb branch", LD_reg_Pb,
				taken ? mask_bit(MASK_NONE, PC_IDX, 1'b0) : MASK_NONE);
			check_mask("INCb branch", INCb, taken ? MASK_NONE : 8'h7f);
			if (taken)
				check_word("pout branch", pout, {12'h000, imm4});
			advance();
			if (taken) begin
				for (k = 0; k < 2; k++) begin	// two squashed cycles
					drive_word(wa);
					check_mask("LD_reg_ALUb slot", LD_reg_ALUb, MASK_NONE);
					advance();
				end
			end
			drive_word(NOP_WORD);
			check_mask("LD_reg_ALUb after branch", LD_reg_ALUb,
				mask_bit(MASK_NONE, d, 1'b0));
			advance();
		end
		r    = next_random();
		d    = r[2:0];
		imm4 = r[7:4];
		present_word({CLS_BRANCH, 1'b1, BA, 1'b0, d, imm4});	// PC = reg + imm
		drive_word(NOP_WORD);
		check_mask("LD_reg_ALUb indirect", LD_reg_ALUb, mask_bit(MASK_NONE, PC_IDX, 1'b0));
		check_op("aluOp indirect", aluOp, ALU_ADD);
		check_idx("ALU_A_SEL indirect", ALU_A_SEL, d);
		check_bit("ALU_B_from_inP_b indirect", ALU_B_from_inP_b, 1'b0);
		check_mask("LD_reg_Pb indirect", LD_reg_Pb, MASK_NONE);
		advance();
	endtask

	task automatic test_memory();
		reg_idx_t idx;
		reg_idx_t d;
		word_t    wa;
		wa  = {CLS_ALU_RR, 4'h1, 1'b0, 3'd6, 1'b0, 3'd0};
		idx = 3'd2;
		d   = 3'd5;
		present_word({CLS_MEM_RR, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, d, 1'b0, idx});	// store, post-inc
		drive_word(NOP_WORD);
		check_bit("mem_WRb store", mem_WRb, 1'b0);
		check_bit("M_ENb store", M_ENb, 1'b0);
		check_bit("mem_OEb store", mem_OEb, 1'b1);
		check_idx("M_SEL store", M_SEL, d);
		check_idx("MADDR_SEL store", MADDR_SEL, idx);
		check_mask("DECb store", DECb, mask_bit(8'h7f, idx, 1'b1));
		check_mask("INCb store", INCb, mask_bit(MASK_NONE, idx, 1'b0));
		advance();
		idx = 3'd4;
		d   = 3'd1;
		present_word({CLS_MEM_RR, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, d, 1'b0, idx});	// load, post-dec
		drive_word(wa);
		check_idx("MADDR_SEL load", MADDR_SEL, idx);
		check_mask("DECb load", DECb, 8'h7f);
		advance();
		drive_word(wa);				// stall cycle
		check_bit("mem_OEb load", mem_OEb, 1'b0);
		check_bit("mem_WRb load", mem_WRb, 1'b1);
		check_idx("MADDR_SEL stage 1", MADDR_SEL, idx);
		check_mask("LD_reg_Mb load", LD_reg_Mb, mask_bit(MASK_NONE, d, 1'b0));
		check_mask("INCb load", INCb, MASK_NONE);
		check_mask("DECb stage 1", DECb, mask_bit(MASK_NONE, idx, 1'b0));
		check_mask("LD_reg_ALUb stall", LD_reg_ALUb, MASK_NONE);
		advance();
		drive_word(NOP_WORD);
		check_mask("LD_reg_ALUb after load", LD_reg_ALUb, MASK_NONE);
		check_mask("LD_reg_Mb after load", LD_reg_Mb, MASK_NONE);
		advance();
	endtask

	task automatic test_inc_dec_multi();
		logic [31:0] r;
		logic [6:0]  m7;
		r  = next_random();
		m7 = r[6:0];
		present_word({CLS_MISC, MISC_INC_MULTI, 1'b0, m7});
		drive_word(NOP_WORD);
		check_mask("INCb multi", INCb, {1'b0, m7});	// PC bit from the fetch
		check_mask("DECb multi", DECb, MASK_NONE);
		advance();
		present_word({CLS_MISC, MISC_DEC_MULTI, 1'b0, m7});
		drive_word(NOP_WORD);
		check_mask("DECb multi", DECb, {1'b1, m7});
		check_mask("INCb fetch", INCb, 8'h7f);
		advance();
	endtask

/* tb_top.sv */
// testbench top for pipeline_ctrl, holds the DUT, check helpers and the directed test sequence
`timescale 1ns/1ps

module tb_top import cpu_isa_pkg::*, cpu_ctrl_pkg::*; ();

	localparam int RESET_TIMEOUT = 16;	// cycles
	localparam int FETCH_TIMEOUT = 8;

	logic      CLK;
	logic      RSTb;
	word_t     memoryIn;
	logic      C;
	logic      Z;
	logic      S;
	alu_op_t   aluOp;
	word_t     pout;
	reg_mask_t LD_reg_ALUb;
	reg_mask_t LD_reg_Mb;
	reg_mask_t LD_reg_Pb;
	reg_idx_t  ALU_A_SEL;
	reg_idx_t  ALU_B_SEL;
	logic      M_ENb;
	reg_idx_t  M_SEL;
	reg_idx_t  MADDR_SEL;
	reg_mask_t INCb;
	reg_mask_t DECb;
	logic      ALU_B_from_inP_b;
	logic      mem_OEb;
	logic      mem_WRb;

	int          errors;
	int          checks;
	int          tests;
	int          failed_tests;
	int          test_errors;		// error count when the test began
	string       test_name;
	logic [31:0] rng;

	tb_clock u_clk (
		.CLK  (CLK),
		.RSTb (RSTb)
	);

	pipeline_ctrl dut (.*);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_random();
		rng = xorshift32(rng);
		return rng;
	endfunction

	// expected mask, one bit forced to v
	function automatic reg_mask_t mask_bit(input reg_mask_t base, input reg_idx_t idx,
		input logic v);
		reg_mask_t m;
		m = base;
		m[idx] = v;
		return m;
	endfunction

	// inputs change here, 5 ns after the edge; leaves at the sample point
	task automatic drive_word(input word_t w);
		memoryIn = w;
		#90;
	endtask

	task automatic advance();
		@(posedge CLK);
		#5;
	endtask

	task automatic check_mask(input string what, input reg_mask_t got, input reg_mask_t exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_idx(input string what, input reg_idx_t got, input reg_idx_t exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("** Error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("** Error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_op(input string what, input alu_op_t got, input alu_op_t exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_word(input string what, input word_t got, input word_t exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// counts as a failure, the sequence carries on to the closing report
	task automatic report_timeout(input string what);
		errors++;
		$display("timeout: gave up waiting for %s at %0d ns", what, $time);
	endtask

	// called at a drive point, returns at the drive point after reset is gone
	task automatic wait_reset_release();
		int n;
		n = 0;
		#90;				// look at reset between edges
		while (RSTb !== 1'b1 && n < RESET_TIMEOUT) begin
			@(posedge CLK);
			#95;
			n++;
		end
		if (RSTb !== 1'b1)
			report_timeout("reset release");
		advance();
	endtask

	// idles on NOP until stage 0 takes memoryIn again
	task automatic wait_fetch_ready();
		int n;
		n = 0;
		while (dut.u_fetch.fetching !== 1'b1 && n < FETCH_TIMEOUT) begin
			drive_word(NOP_WORD);
			advance();
			n++;
		end
		if (dut.u_fetch.fetching !== 1'b1)
			report_timeout("instruction fetch to resume");
	endtask

	// returns with w sitting in stage 0
	task automatic present_word(input word_t w);
		wait_fetch_ready();
		drive_word(w);
		advance();
	endtask

	task automatic start_test(input string name);
		test_name   = name;
		test_errors = errors;
	endtask

	task automatic finish_test();
		tests++;
		if (errors == test_errors) begin
			$display("test %s: passed", test_name);
		end else begin
			failed_tests++;
			$display("test %s: failed with %0d errors", test_name, errors - test_errors);
		end
	endtask

	`include "tb_tests.svh"

	initial begin
		memoryIn     = NOP_WORD;
		C            = 1'b0;
		Z            = 1'b0;
		S            = 1'b0;
		errors       = 0;
		checks       = 0;
		tests        = 0;
		failed_tests = 0;
		test_errors  = 0;
		rng          = 32'hdbf4;
		advance();

		start_test("reset and idle fetch");
		test_reset_idle();
		finish_test();
		start_test("alu classes");
		test_alu_classes();
		finish_test();
		start_test("immediate prefix");
		test_imm_prefix();
		finish_test();
		start_test("absolute branches");
		test_branches();
		finish_test();
		start_test("memory access");
		test_memory();
		finish_test();
		start_test("inc and dec multiple");
		test_inc_dec_multi();
		finish_test();

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests, failed_tests, checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* sim.f */
+incdir+.
cpu_isa_pkg.sv
cpu_ctrl_pkg.sv
fetch_sequencer.sv
stage0_decode.sv
stage1_decode.sv
pipeline_ctrl.sv
tb_clock.sv
tb_top.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_top
FILELIST  = sim.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir
